// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

   // Address and line geometry.
   localparam int ADDR_WIDTH      = 32;
   localparam int LINE_BYTES_LOG2 = 4;  // 16-byte lines.
   localparam int FIP_WIDTH       = ADDR_WIDTH - LINE_BYTES_LOG2;
   localparam int LINE_WIDTH      = 128;

   // Each bank holds every other line, indexed by FIP[6:1].
   localparam int BANK_INDEX_WIDTH = 6;
   localparam int BANK_DEPTH       = 1 << BANK_INDEX_WIDTH;
   localparam int FIP_STEP         = 2;

   // Bit positions in the one-hot control-flow select.
   localparam int CF_INIT    = 2;
   localparam int CF_RESTEER = 1;
   localparam int CF_BRANCH  = 0;

   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [FIP_WIDTH-1:0]  fip_t;
   typedef logic [LINE_WIDTH-1:0] line_t;
   typedef logic [2:0]            cf_sel_t;

endpackage

`default_nettype wire

// ==== fetch_redirect.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_redirect
   import fetch_pkg::*;
(
   input  addr_t   init_addr,
   input  logic    is_init,
   input  logic    is_resteer,
   input  logic    is_br_taken,
   output cf_sel_t cf_sel,
   output logic    is_ctrl_flow,
   output fip_t    init_fip_even,
   output fip_t    init_fip_odd
);

   fip_t init_fip;
   fip_t init_fip_next;

   assign init_fip      = init_addr[ADDR_WIDTH-1:LINE_BYTES_LOG2];
   assign init_fip_next = init_fip + fip_t'(1);

   // Init beats resteer, resteer beats a taken branch.
   always_comb begin
      cf_sel = '0;
      if (is_init) begin
         cf_sel[CF_INIT] = 1'b1;
      end else if (is_resteer) begin
         cf_sel[CF_RESTEER] = 1'b1;
      end else if (is_br_taken) begin
         cf_sel[CF_BRANCH] = 1'b1;
      end
   end

   assign is_ctrl_flow = is_init | is_resteer | is_br_taken;

   // The line at init_addr goes to its own bank, the next line to the other.
   assign init_fip_even = init_fip[0] ? init_fip_next : init_fip;
   assign init_fip_odd  = init_fip[0] ? init_fip : init_fip_next;

endmodule

`default_nettype wire

// ==== fetch_bank_pointer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_bank_pointer
   import fetch_pkg::*;
#(
   parameter int BANK_ID = 0
) (
   input  logic    clk,
   input  logic    rst_n,
   input  fip_t    init_fip,
   input  fip_t    bp_fip,
   input  fip_t    wb_fip,
   input  cf_sel_t cf_sel,
   input  logic    is_ctrl_flow,
   input  logic    ld_fip,
   input  logic    fetch_req,
   output fip_t    access_fip
);

   fip_t cf_fip;
   fip_t fip_reg;

   // AND-OR select over a one-hot cf_sel.
   assign cf_fip = ({FIP_WIDTH{cf_sel[CF_INIT]}}    & init_fip)
                 | ({FIP_WIDTH{cf_sel[CF_RESTEER]}} & wb_fip)
                 | ({FIP_WIDTH{cf_sel[CF_BRANCH]}}  & bp_fip);

   assign access_fip = is_ctrl_flow ? cf_fip : fip_reg;

   // Sequential FIP, one line pair ahead of the last access.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fip_reg <= '0;
      end else if (ld_fip) begin
         fip_reg <= access_fip + fip_t'(FIP_STEP);
      end
   end

   // The AND-OR select needs exactly one source whenever control flow is active.
   a_cf_sel_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(cf_sel) && ((|cf_sel) == is_ctrl_flow)
   ) else $error("bank %0d cf_sel %b does not match is_ctrl_flow %b",
                 BANK_ID, cf_sel, is_ctrl_flow);

   // Control-flow FIPs from outside must already carry this bank's parity.
   a_cf_parity: assert property (
      @(posedge clk) disable iff (!rst_n)
      (fetch_req && is_ctrl_flow) |-> (access_fip[0] == 1'(BANK_ID))
   ) else $error("bank %0d access_fip %h has wrong parity", BANK_ID, access_fip);

endmodule

`default_nettype wire

// ==== icache_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_bank
   import fetch_pkg::*;
#(
   parameter int BANK_ID = 0
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  fill_en,
   input  fip_t  fill_fip,
   input  line_t fill_line,
   input  logic  fetch_req,
   input  fip_t  access_fip,
   output logic  rd_valid,
   output line_t rd_line,
   output fip_t  rd_fip
);

   line_t                       mem [BANK_DEPTH];
   logic [BANK_INDEX_WIDTH-1:0] fill_idx;
   logic [BANK_INDEX_WIDTH-1:0] rd_idx;
   logic                        fill_hit;

   // Bit 0 selects the bank, so the index starts at bit 1.
   assign fill_idx = fill_fip[BANK_INDEX_WIDTH:1];
   assign rd_idx   = access_fip[BANK_INDEX_WIDTH:1];
   assign fill_hit = fill_en && (fill_fip[0] == 1'(BANK_ID));

   always_ff @(posedge clk) begin
      if (fill_hit) begin
         mem[fill_idx] <= fill_line;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= fetch_req;
      end
   end

   // A same-cycle fill is seen only by later reads.
   always_ff @(posedge clk) begin
      if (fetch_req) begin
         rd_line <= mem[rd_idx];
         rd_fip  <= access_fip;
      end
   end

   a_rd_valid_known: assert property (
      @(posedge clk) disable iff (!rst_n) !$isunknown(rd_valid)
   ) else $error("bank %0d rd_valid is unknown", BANK_ID);

endmodule

`default_nettype wire

// ==== fetch_line_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_line_aligner
   import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  even_valid,
   input  logic  odd_valid,
   input  line_t even_line,
   input  line_t odd_line,
   input  fip_t  even_fip,
   input  fip_t  odd_fip,
   output logic  line_valid,
   output line_t line_lo,
   output line_t line_hi,
   output fip_t  fetch_fip
);

   logic both_valid;
   logic even_first;

   assign both_valid = even_valid & odd_valid;
   assign even_first = even_fip < odd_fip;  // Lower address goes first.

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         line_valid <= 1'b0;
      end else begin
         line_valid <= both_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (both_valid) begin
         if (even_first) begin
            line_lo   <= even_line;
            line_hi   <= odd_line;
            fetch_fip <= even_fip;
         end else begin
            line_lo   <= odd_line;
            line_hi   <= even_line;
            fetch_fip <= odd_fip;
         end
      end
   end

   // Both banks share fetch_req, so their reads must come back together.
   a_banks_in_step: assert property (
      @(posedge clk) disable iff (!rst_n) even_valid == odd_valid
   ) else $error("bank reads out of step, even %b odd %b", even_valid, odd_valid);

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top
   import fetch_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  addr_t init_addr,
   input  logic  is_init,
   input  fip_t  bp_fip_even,
   input  fip_t  bp_fip_odd,
   input  logic  is_br_taken,
   input  fip_t  wb_fip_even,
   input  fip_t  wb_fip_odd,
   input  logic  is_resteer,
   input  logic  even_latch_was_loaded,
   input  logic  odd_latch_was_loaded,
   input  logic  fetch_req,
   input  logic  fill_en,
   input  fip_t  fill_fip,
   input  line_t fill_line,
   output logic  line_valid,
   output line_t line_lo,
   output line_t line_hi,
   output fip_t  fetch_fip
);

   cf_sel_t cf_sel;
   logic    is_ctrl_flow;
   fip_t    init_fip_even;
   fip_t    init_fip_odd;
   fip_t    even_access_fip;
   fip_t    odd_access_fip;
   logic    even_rd_valid;
   logic    odd_rd_valid;
   line_t   even_rd_line;
   line_t   odd_rd_line;
   fip_t    even_rd_fip;
   fip_t    odd_rd_fip;

   fetch_redirect u_redirect (
      .init_addr    (init_addr),
      .is_init      (is_init),
      .is_resteer   (is_resteer),
      .is_br_taken  (is_br_taken),
      .cf_sel       (cf_sel),
      .is_ctrl_flow (is_ctrl_flow),
      .init_fip_even(init_fip_even),
      .init_fip_odd (init_fip_odd)
   );

   fetch_bank_pointer #(.BANK_ID(0)) u_ptr_even (
      .clk(clk), .rst_n(rst_n),
      .init_fip(init_fip_even), .bp_fip(bp_fip_even), .wb_fip(wb_fip_even),
      .cf_sel(cf_sel), .is_ctrl_flow(is_ctrl_flow),
      .ld_fip(even_latch_was_loaded), .fetch_req(fetch_req),
      .access_fip(even_access_fip)
   );

   fetch_bank_pointer #(.BANK_ID(1)) u_ptr_odd (
      .clk(clk), .rst_n(rst_n),
      .init_fip(init_fip_odd), .bp_fip(bp_fip_odd), .wb_fip(wb_fip_odd),
      .cf_sel(cf_sel), .is_ctrl_flow(is_ctrl_flow),
      .ld_fip(odd_latch_was_loaded), .fetch_req(fetch_req),
      .access_fip(odd_access_fip)
   );

   icache_bank #(.BANK_ID(0)) u_bank_even (
      .clk(clk), .rst_n(rst_n),
      .fill_en(fill_en), .fill_fip(fill_fip), .fill_line(fill_line),
      .fetch_req(fetch_req), .access_fip(even_access_fip),
      .rd_valid(even_rd_valid), .rd_line(even_rd_line), .rd_fip(even_rd_fip)
   );

   icache_bank #(.BANK_ID(1)) u_bank_odd (
      .clk(clk), .rst_n(rst_n),
      .fill_en(fill_en), .fill_fip(fill_fip), .fill_line(fill_line),
      .fetch_req(fetch_req), .access_fip(odd_access_fip),
      .rd_valid(odd_rd_valid), .rd_line(odd_rd_line), .rd_fip(odd_rd_fip)
   );

   fetch_line_aligner u_aligner (
      .clk(clk), .rst_n(rst_n),
      .even_valid(even_rd_valid), .odd_valid(odd_rd_valid),
      .even_line(even_rd_line), .odd_line(odd_rd_line),
      .even_fip(even_rd_fip), .odd_fip(odd_rd_fip),
      .line_valid(line_valid), .line_lo(line_lo), .line_hi(line_hi),
      .fetch_fip(fetch_fip)
   );

endmodule

`default_nettype wire

// ==== tb_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch
   import fetch_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int FILL_CYCLES  = 2 * BANK_DEPTH + 2;
   localparam int TEST_CYCLES  = 30;  // Five directed tests together.
   localparam int LIMIT_CYCLES = RESET_CYCLES + FILL_CYCLES + TEST_CYCLES + 50;

   logic  clk;
   logic  rst_n;
   addr_t init_addr;
   logic  is_init;
   fip_t  bp_fip_even;
   fip_t  bp_fip_odd;
   logic  is_br_taken;
   fip_t  wb_fip_even;
   fip_t  wb_fip_odd;
   logic  is_resteer;
   logic  even_latch_was_loaded;
   logic  odd_latch_was_loaded;
   logic  fetch_req;
   logic  fill_en;
   fip_t  fill_fip;
   line_t fill_line;
   logic  line_valid;
   line_t line_lo;
   line_t line_hi;
   fip_t  fetch_fip;

   line_t       ref_mem [2 * BANK_DEPTH];  // One entry per FIP[6:0] over both banks.
   logic [31:0] rng_state;
   int          error_count;
   int          check_count;

   fetch_top dut (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic line_t next_line();
      line_t l;
      l = '0;
      for (int i = 0; i < LINE_WIDTH / 32; i++) begin
         rng_state = xorshift32(rng_state);
         l = {l[LINE_WIDTH-33:0], rng_state};
      end
      return l;
   endfunction

   task automatic check_line(input string name, input line_t got, input line_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_fip(input string name, input fip_t got, input fip_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   // Called at a rising edge.
   task automatic drive(input logic req, input logic ld, input logic init,
                        input logic resteer, input logic branch);
      fetch_req             <= req;
      even_latch_was_loaded <= ld;
      odd_latch_was_loaded  <= ld;
      is_init               <= init;
      is_resteer            <= resteer;
      is_br_taken           <= branch;
      fill_en               <= 1'b0;
   endtask

   task automatic expect_window(input fip_t lo_fip, input line_t lo_exp, input line_t hi_exp);
      @(negedge clk);
      check_count++;
      if (line_valid !== 1'b1) begin
         error_count++;
         $display("line_valid did not rise two cycles after fetch_req");
      end else begin
         check_fip("fetch_fip", fetch_fip, lo_fip);
         check_line("line_lo", line_lo, lo_exp);
         check_line("line_hi", line_hi, hi_exp);
      end
   endtask

   // Expected FIPs are given in address order, lower line first.
   task automatic fetch_window(input logic ld, input logic init, input logic resteer,
                               input logic branch, input fip_t lo_fip, input fip_t hi_fip);
      drive(1'b1, ld, init, resteer, branch);
      @(posedge clk);
      drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      @(posedge clk);
      expect_window(lo_fip, ref_mem[lo_fip[BANK_INDEX_WIDTH:0]],
                    ref_mem[hi_fip[BANK_INDEX_WIDTH:0]]);
   endtask

   task automatic fill_banks();
      fip_t fip;
      for (int i = 0; i < 2 * BANK_DEPTH; i++) begin
         fip = fip_t'(i);
         @(posedge clk);
         ref_mem[fip[BANK_INDEX_WIDTH:0]] = next_line();
         fill_en   <= 1'b1;
         fill_fip  <= fip;
         fill_line <= ref_mem[fip[BANK_INDEX_WIDTH:0]];
      end
      @(posedge clk);
      fill_en <= 1'b0;
   endtask

   task automatic test_aligned_init();
      @(posedge clk);
      init_addr <= 32'h1234_5600;  // High FIP bits wrap onto index 0x60.
      fetch_window(1'b0, 1'b1, 1'b0, 1'b0, 28'h123_4560, 28'h123_4561);
   endtask

   task automatic test_misaligned_init();
      @(posedge clk);
      init_addr <= 32'h0000_0A10;
      fetch_window(1'b0, 1'b1, 1'b0, 1'b0, 28'h000_00A1, 28'h000_00A2);
   endtask

   task automatic test_sequential();
      @(posedge clk);
      init_addr <= 32'h0000_0300;
      drive(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
      @(posedge clk);
      fetch_window(1'b1, 1'b0, 1'b0, 1'b0, 28'h000_0032, 28'h000_0033);
      @(posedge clk);
      fetch_window(1'b1, 1'b0, 1'b0, 1'b0, 28'h000_0034, 28'h000_0035);
   endtask

   task automatic test_priority();
      @(posedge clk);
      init_addr   <= 32'h0000_0640;
      bp_fip_even <= 28'hABC_DE20;
      bp_fip_odd  <= 28'hABC_DE21;
      wb_fip_even <= 28'h000_0036;
      wb_fip_odd  <= 28'h000_0035;
      fetch_window(1'b0, 1'b1, 1'b1, 1'b1, 28'h000_0064, 28'h000_0065);
      @(posedge clk);
      fetch_window(1'b0, 1'b0, 1'b1, 1'b1, 28'h000_0035, 28'h000_0036);
      @(posedge clk);
      fetch_window(1'b0, 1'b0, 1'b0, 1'b1, 28'hABC_DE20, 28'hABC_DE21);
   endtask

   task automatic test_pipeline();
      line_t old_lo;
      line_t new_lo;
      line_t hi;
      @(posedge clk);
      init_addr <= 32'h0000_0500;  // Pointers load 0x52 and 0x53.
      drive(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
      @(posedge clk);
      drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      @(posedge clk);
      old_lo = ref_mem[7'h52];
      hi     = ref_mem[7'h53];
      new_lo = next_line();
      drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      fill_en   <= 1'b1;  // Lands with the second fetch.
      fill_fip  <= 28'h000_0052;
      fill_line <= new_lo;
      @(posedge clk);
      drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      ref_mem[7'h52] = new_lo;
      expect_window(28'h000_0052, old_lo, hi);
      @(posedge clk);
      drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      expect_window(28'h000_0052, old_lo, hi);
      @(posedge clk);
      expect_window(28'h000_0052, new_lo, hi);
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, tests did not finish", LIMIT_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      rst_n                 = 1'b0;
      init_addr             = '0;
      is_init               = 1'b0;
      bp_fip_even           = '0;
      bp_fip_odd            = '0;
      is_br_taken           = 1'b0;
      wb_fip_even           = '0;
      wb_fip_odd            = '0;
      is_resteer            = 1'b0;
      even_latch_was_loaded = 1'b0;
      odd_latch_was_loaded  = 1'b0;
      fetch_req             = 1'b0;
      fill_en               = 1'b0;
      fill_fip              = '0;
      fill_line             = '0;
      rng_state             = 32'd25;
      error_count           = 0;
      check_count           = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      fill_banks();
      test_aligned_init();
      test_misaligned_init();
      test_sequential();
      test_priority();
      test_pipeline();
      @(posedge clk);
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
fetch_pkg.sv
fetch_redirect.sv
fetch_bank_pointer.sv
icache_bank.sv
fetch_line_aligner.sv
fetch_top.sv
tb_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
